//--- dv/axi_sram_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axi_sram_tb;

  localparam int addr_width = 20;
  localparam int data_width = 16;
  localparam int id_width = 4;
  localparam int strb_width = data_width / 8;
  localparam int word_shift = $clog2(strb_width);
  localparam logic [1:0] okay = 2'b00;
  localparam logic [1:0] incr = 2'b01;

  typedef struct {
    bit                    is_read;
    bit                    overlap;
    logic [addr_width-1:0] addr;
    int                    beats;
    logic [id_width-1:0]   id;
    logic [strb_width-1:0] strb;
    logic [data_width-1:0] seed;
    logic [7:0]            rstall;
    logic [7:0]            bstall;
  } row_t;

  logic clk = 1'b0;
  logic rst_n;
  logic s_axi_arvalid, s_axi_arready, s_axi_rvalid, s_axi_rready, s_axi_rlast;
  logic s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready, s_axi_wlast;
  logic s_axi_bvalid, s_axi_bready;
  logic [id_width-1:0]   s_axi_arid, s_axi_rid, s_axi_awid, s_axi_bid;
  logic [addr_width-1:0] s_axi_araddr, s_axi_awaddr;
  logic [7:0]            s_axi_arlen, s_axi_awlen;
  logic [2:0]            s_axi_arsize, s_axi_awsize;
  logic [1:0]            s_axi_arburst, s_axi_awburst, s_axi_rresp, s_axi_bresp;
  logic [data_width-1:0] s_axi_rdata, s_axi_wdata;
  logic [strb_width-1:0] s_axi_wstrb;

  row_t                  rows [$];
  logic [data_width-1:0] ref_mem [int];
  int unsigned           cycle_count = 0;
  int unsigned           cycle_limit = 200;
  int                    rows_passed = 0;
  int                    rows_failed = 0;

  axi_sram_top u_dut (.*);

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  function automatic void add_row(input bit is_read, input bit overlap,
                                  input logic [addr_width-1:0] addr, input int beats,
                                  input logic [id_width-1:0] id,
                                  input logic [strb_width-1:0] strb,
                                  input logic [data_width-1:0] seed,
                                  input logic [7:0] rstall, input logic [7:0] bstall);
    row_t r;
    r.is_read = is_read;
    r.overlap = overlap;
    r.addr = addr;
    r.beats = beats;
    r.id = id;
    r.strb = strb;
    r.seed = seed;
    r.rstall = rstall;
    r.bstall = bstall;
    rows.push_back(r);
  endfunction

  // Byte lanes follow the strobe, the rest keep the old word
  function automatic void store_ref(input int word, input logic [data_width-1:0] data,
                                    input logic [strb_width-1:0] strb);
    logic [data_width-1:0] cur;
    cur = ref_mem.exists(word) ? ref_mem[word] : '0;
    for (int lane = 0; lane < strb_width; lane++) begin
      if (strb[lane]) cur[lane*8 +: 8] = data[lane*8 +: 8];
    end
    ref_mem[word] = cur;
  endfunction

  task automatic check(input bit ok, input string msg, inout int fails);
    assert (ok) else begin
      $display("FAIL %0t: %s", $time, msg);
      fails++;
    end
  endtask

  task automatic run_write(input row_t r, inout int fails);
    int word;
    int k;
    bit b_done;
    logic [data_width-1:0] data;
    word = int'(r.addr >> word_shift);
    @(posedge clk);
    s_axi_awvalid <= 1'b1;
    s_axi_awid <= r.id;
    s_axi_awaddr <= r.addr;
    s_axi_awlen <= 8'(r.beats - 1);
    s_axi_awsize <= 3'(word_shift);
    s_axi_awburst <= incr;
    do @(negedge clk); while (!s_axi_awready);
    for (int beat = 0; beat < r.beats; beat++) begin
      data = 16'($urandom()) ^ r.seed;
      @(posedge clk);
      s_axi_awvalid <= 1'b0;
      s_axi_wvalid <= 1'b1;
      s_axi_wdata <= data;
      s_axi_wstrb <= r.strb;
      s_axi_wlast <= (beat == r.beats - 1);
      do @(negedge clk); while (!s_axi_wready);
      store_ref(word + beat, data, r.strb);
    end
    @(posedge clk);
    s_axi_wvalid <= 1'b0;
    s_axi_wlast <= 1'b0;
    k = 0;
    b_done = 1'b0;
    while (!b_done) begin
      @(posedge clk);
      s_axi_bready <= !r.bstall[k % 8];
      k++;
      @(negedge clk);
      if (s_axi_bvalid && s_axi_bready) b_done = 1'b1;
    end
    check(s_axi_bid === r.id, $sformatf("bid %h, expected %h", s_axi_bid, r.id), fails);
    check(s_axi_bresp === okay, $sformatf("bresp %b is not OKAY", s_axi_bresp), fails);
    @(posedge clk);
    s_axi_bready <= 1'b0;
    @(negedge clk);
    check(s_axi_bvalid === 1'b0, "second B response after burst", fails);
  endtask

  task automatic run_read(input row_t r, inout int fails);
    int word;
    int k;
    bit got;
    bit held;
    logic [data_width-1:0] held_data;
    logic [id_width-1:0]   held_id;
    logic [data_width-1:0] exp_data;
    word = int'(r.addr >> word_shift);
    k = 0;
    @(posedge clk);
    s_axi_arvalid <= 1'b1;
    s_axi_arid <= r.id;
    s_axi_araddr <= r.addr;
    s_axi_arlen <= 8'(r.beats - 1);
    s_axi_arsize <= 3'(word_shift);
    s_axi_arburst <= incr;
    do @(negedge clk); while (!s_axi_arready);
    for (int beat = 0; beat < r.beats; beat++) begin
      got = 1'b0;
      held = 1'b0;
      while (!got) begin
        @(posedge clk);
        if (k == 0) s_axi_arvalid <= 1'b0;
        s_axi_rready <= !r.rstall[k % 8];
        k++;
        @(negedge clk);
        // A stalled beat must not change
        if (held) begin
          check(s_axi_rvalid && s_axi_rdata === held_data && s_axi_rid === held_id,
                "R beat changed while rready was low", fails);
        end
        if (s_axi_rvalid && s_axi_rready) begin
          got = 1'b1;
          exp_data = ref_mem[word + beat];
          check(s_axi_rdata === exp_data, $sformatf("rdata %h at word %h, expected %h",
                s_axi_rdata, word + beat, exp_data), fails);
          check(s_axi_rid === r.id, $sformatf("rid %h, expected %h", s_axi_rid, r.id), fails);
          check(s_axi_rresp === okay, $sformatf("rresp %b is not OKAY", s_axi_rresp), fails);
          check(s_axi_rlast === (beat == r.beats - 1),
                $sformatf("rlast %b on beat %0d", s_axi_rlast, beat), fails);
        end else if (s_axi_rvalid) begin
          held = 1'b1;
          held_data = s_axi_rdata;
          held_id = s_axi_rid;
        end
      end
    end
    @(posedge clk);
    s_axi_rready <= 1'b0;
  endtask

  task automatic run_row(input int idx);
    int fails;
    fails = 0;
    if (rows[idx].is_read) run_read(rows[idx], fails);
    else run_write(rows[idx], fails);
    $display("Row %0d %s addr %h, %0d beats: %s", idx, rows[idx].is_read ? "read" : "write",
             rows[idx].addr, rows[idx].beats, fails == 0 ? "ok" : "FAILED");
    if (fails == 0) rows_passed++;
    else rows_failed++;
  endtask

  initial begin
    int fails;
    int i;
    void'($urandom(83));
    rst_n <= 1'b0;
    s_axi_arvalid <= 1'b0;
    s_axi_arid <= '0;
    s_axi_araddr <= '0;
    s_axi_arlen <= '0;
    s_axi_arsize <= '0;
    s_axi_arburst <= '0;
    s_axi_rready <= 1'b0;
    s_axi_awvalid <= 1'b0;
    s_axi_awid <= '0;
    s_axi_awaddr <= '0;
    s_axi_awlen <= '0;
    s_axi_awsize <= '0;
    s_axi_awburst <= '0;
    s_axi_wvalid <= 1'b0;
    s_axi_wdata <= '0;
    s_axi_wstrb <= '0;
    s_axi_wlast <= 1'b0;
    s_axi_bready <= 1'b0;

    // read, overlap, addr, beats, id, strb, seed, rready stall, bready stall
    add_row(0, 0, 20'h00100, 1, 4'h3, 2'b11, 16'h1234, 8'h00, 8'h00);
    add_row(1, 0, 20'h00100, 1, 4'h3, 2'b11, 16'h0000, 8'h00, 8'h00);
    add_row(0, 0, 20'h00200, 4, 4'h5, 2'b11, 16'ha5a5, 8'h00, 8'b0000_0111);
    add_row(1, 0, 20'h00200, 4, 4'h9, 2'b11, 16'h0000, 8'h00, 8'h00);
    add_row(0, 0, 20'h00202, 1, 4'h2, 2'b01, 16'h0f0f, 8'h00, 8'h00);
    add_row(0, 0, 20'h00100, 1, 4'h6, 2'b10, 16'h5a5a, 8'h00, 8'h00);
    add_row(1, 0, 20'h00200, 4, 4'h7, 2'b11, 16'h0000, 8'b0011_1101, 8'h00);
    add_row(1, 0, 20'h00100, 1, 4'h1, 2'b11, 16'h0000, 8'b0000_1111, 8'h00);
    add_row(0, 1, 20'h00400, 8, 4'h4, 2'b11, 16'hc3c3, 8'h00, 8'h00);
    add_row(1, 0, 20'h00200, 4, 4'h8, 2'b11, 16'h0000, 8'h00, 8'h00);
    add_row(1, 0, 20'h00400, 8, 4'h4, 2'b11, 16'h0000, 8'b0101_0101, 8'h00);
    add_row(0, 1, 20'h00600, 2, 4'hf, 2'b11, 16'h7e7e, 8'h00, 8'b1100_0011);
    add_row(1, 0, 20'h00400, 8, 4'hc, 2'b11, 16'h0000, 8'b1001_0010, 8'h00);
    add_row(1, 0, 20'h00600, 2, 4'hf, 2'b11, 16'h0000, 8'h00, 8'h00);
    foreach (rows[j]) cycle_limit += (rows[j].beats + 1) * 8;

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    fails = 0;
    check(s_axi_arready === 1'b1 && s_axi_awready === 1'b1, "ready low after reset", fails);
    check(s_axi_rvalid === 1'b0 && s_axi_bvalid === 1'b0, "valid high after reset", fails);
    check(s_axi_wready === 1'b0, "wready high before any write address", fails);
    $display("Reset state: %s", fails == 0 ? "ok" : "FAILED");
    if (fails == 0) rows_passed++;
    else rows_failed++;

    // Overlapping rows run together with the row after them
    i = 0;
    while (i < rows.size()) begin
      if (rows[i].overlap && i + 1 < rows.size()) begin
        fork
          run_row(i);
          run_row(i + 1);
        join
        i += 2;
      end else begin
        run_row(i);
        i++;
      end
    end

    repeat (4) @(posedge clk);
    $display("Tests passed: %0d, tests failed: %0d", rows_passed, rows_failed);
    if (rows_failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    @(posedge clk);
    while (cycle_count < cycle_limit) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
verilog/axi_sram_pkg.sv
verilog/sram_rd_if.sv
verilog/sram_wr_if.sv
verilog/axi_sram_rd.sv
verilog/axi_sram_wr.sv
verilog/sram_port_arb.sv
verilog/axi_sram_top.sv
dv/axi_sram_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module axi_sram_tb -o sim_axi_sram
out=$(./obj_dir/sim_axi_sram)
echo "$out"

if echo "$out" | grep -q "All tests passed"; then
  exit 0
fi
exit 1

//--- verilog/axi_sram_pkg.sv
`default_nettype none

package axi_sram_pkg;

  // Default AXI geometry
  localparam int axi_addr_width = 20;
  localparam int axi_data_width = 16;
  localparam int axi_id_width = 4;

  localparam logic [1:0] burst_incr = 2'b01;
  localparam logic [1:0] resp_okay = 2'b00;

  // Read meta is {id, last}, last in bit 0
  function automatic int meta_width(input int id_width);
    return id_width + 1;
  endfunction

  // Byte address bits below one data word
  function automatic int addr_lsb(input int data_width);
    return $clog2(data_width) - 3;
  endfunction

endpackage

`default_nettype wire

//--- verilog/axi_sram_rd.sv
`timescale 1ns/1ps
`default_nettype none

module axi_sram_rd #(
  parameter int AXI_ADDR_WIDTH = axi_sram_pkg::axi_addr_width,
  parameter int AXI_DATA_WIDTH = axi_sram_pkg::axi_data_width,
  parameter int AXI_ID_WIDTH   = axi_sram_pkg::axi_id_width
) (
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic                      s_axi_arvalid,
  output logic                      s_axi_arready,
  input  logic [  AXI_ID_WIDTH-1:0] s_axi_arid,
  input  logic [AXI_ADDR_WIDTH-1:0] s_axi_araddr,
  input  logic [               7:0] s_axi_arlen,
  input  logic [               2:0] s_axi_arsize,
  input  logic [               1:0] s_axi_arburst,

  output logic                      s_axi_rvalid,
  input  logic                      s_axi_rready,
  output logic [  AXI_ID_WIDTH-1:0] s_axi_rid,
  output logic [AXI_DATA_WIDTH-1:0] s_axi_rdata,
  output logic [               1:0] s_axi_rresp,
  output logic                      s_axi_rlast,

  sram_rd_if.client                 sram
);

  import axi_sram_pkg::*;

  localparam int ADDR_LSB = addr_lsb(AXI_DATA_WIDTH);
  localparam int SRAM_ADDR_WIDTH = AXI_ADDR_WIDTH - ADDR_LSB;
  localparam int META_WIDTH = meta_width(AXI_ID_WIDTH);

  logic                       active;
  logic [SRAM_ADDR_WIDTH-1:0] word_addr;
  logic [                7:0] beats_left;
  logic [   AXI_ID_WIDTH-1:0] burst_id;

  logic                       ar_fire;
  logic                       cmd_fire;
  logic                       last_beat;

  assign s_axi_arready = ~active;
  assign ar_fire       = s_axi_arvalid & s_axi_arready;
  assign cmd_fire      = sram.cmd_valid & sram.cmd_ready;
  assign last_beat     = (beats_left == 8'd0);

  // Burst state, one SRAM read per beat
  always_ff @(posedge clk) begin
    if (~rst_n) begin
      active <= 1'b0;
    end else if (ar_fire) begin
      active <= 1'b1;
    end else if (cmd_fire && last_beat) begin
      active <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      word_addr  <= s_axi_araddr[AXI_ADDR_WIDTH-1:ADDR_LSB];
      beats_left <= s_axi_arlen;
      burst_id   <= s_axi_arid;
    end else if (cmd_fire && !last_beat) begin
      word_addr  <= word_addr + 1'b1;
      beats_left <= beats_left - 8'd1;
    end
  end

  assign sram.cmd_valid = active;
  assign sram.cmd_addr  = word_addr;
  assign sram.cmd_meta  = {burst_id, last_beat};

  // R beats come straight from the arbiter response
  assign s_axi_rvalid    = sram.resp_valid;
  assign s_axi_rdata     = sram.resp_data;
  assign s_axi_rid       = sram.resp_meta[META_WIDTH-1:1];
  assign s_axi_rlast     = sram.resp_meta[0];
  assign s_axi_rresp     = resp_okay;
  assign sram.resp_ready = s_axi_rready;

endmodule

`default_nettype wire

//--- verilog/axi_sram_top.sv
`timescale 1ns/1ps
`default_nettype none

module axi_sram_top #(
  parameter int AXI_ADDR_WIDTH = axi_sram_pkg::axi_addr_width,
  parameter int AXI_DATA_WIDTH = axi_sram_pkg::axi_data_width,
  parameter int AXI_ID_WIDTH   = axi_sram_pkg::axi_id_width
) (
  input  logic                        clk,
  input  logic                        rst_n,

  input  logic                        s_axi_arvalid,
  output logic                        s_axi_arready,
  input  logic [    AXI_ID_WIDTH-1:0] s_axi_arid,
  input  logic [  AXI_ADDR_WIDTH-1:0] s_axi_araddr,
  input  logic [                 7:0] s_axi_arlen,
  input  logic [                 2:0] s_axi_arsize,
  input  logic [                 1:0] s_axi_arburst,

  output logic                        s_axi_rvalid,
  input  logic                        s_axi_rready,
  output logic [    AXI_ID_WIDTH-1:0] s_axi_rid,
  output logic [  AXI_DATA_WIDTH-1:0] s_axi_rdata,
  output logic [                 1:0] s_axi_rresp,
  output logic                        s_axi_rlast,

  input  logic                        s_axi_awvalid,
  output logic                        s_axi_awready,
  input  logic [    AXI_ID_WIDTH-1:0] s_axi_awid,
  input  logic [  AXI_ADDR_WIDTH-1:0] s_axi_awaddr,
  input  logic [                 7:0] s_axi_awlen,
  input  logic [                 2:0] s_axi_awsize,
  input  logic [                 1:0] s_axi_awburst,

  input  logic                        s_axi_wvalid,
  output logic                        s_axi_wready,
  input  logic [  AXI_DATA_WIDTH-1:0] s_axi_wdata,
  input  logic [AXI_DATA_WIDTH/8-1:0] s_axi_wstrb,
  input  logic                        s_axi_wlast,

  output logic                        s_axi_bvalid,
  input  logic                        s_axi_bready,
  output logic [    AXI_ID_WIDTH-1:0] s_axi_bid,
  output logic [                 1:0] s_axi_bresp
);

  import axi_sram_pkg::*;

  localparam int SRAM_ADDR_WIDTH = AXI_ADDR_WIDTH - addr_lsb(AXI_DATA_WIDTH);
  localparam int META_WIDTH = meta_width(AXI_ID_WIDTH);

  sram_rd_if #(
    .ADDR_WIDTH(SRAM_ADDR_WIDTH),
    .DATA_WIDTH(AXI_DATA_WIDTH),
    .META_WIDTH(META_WIDTH)
  ) u_rd_if ();

  sram_wr_if #(
    .ADDR_WIDTH(SRAM_ADDR_WIDTH),
    .DATA_WIDTH(AXI_DATA_WIDTH),
    .STRB_WIDTH(AXI_DATA_WIDTH / 8)
  ) u_wr_if ();

  axi_sram_rd #(
    .AXI_ADDR_WIDTH(AXI_ADDR_WIDTH),
    .AXI_DATA_WIDTH(AXI_DATA_WIDTH),
    .AXI_ID_WIDTH  (AXI_ID_WIDTH)
  ) u_rd (
    .clk          (clk),
    .rst_n        (rst_n),
    .s_axi_arvalid(s_axi_arvalid),
    .s_axi_arready(s_axi_arready),
    .s_axi_arid   (s_axi_arid),
    .s_axi_araddr (s_axi_araddr),
    .s_axi_arlen  (s_axi_arlen),
    .s_axi_arsize (s_axi_arsize),
    .s_axi_arburst(s_axi_arburst),
    .s_axi_rvalid (s_axi_rvalid),
    .s_axi_rready (s_axi_rready),
    .s_axi_rid    (s_axi_rid),
    .s_axi_rdata  (s_axi_rdata),
    .s_axi_rresp  (s_axi_rresp),
    .s_axi_rlast  (s_axi_rlast),
    .sram         (u_rd_if.client)
  );

  axi_sram_wr #(
    .AXI_ADDR_WIDTH(AXI_ADDR_WIDTH),
    .AXI_DATA_WIDTH(AXI_DATA_WIDTH),
    .AXI_ID_WIDTH  (AXI_ID_WIDTH)
  ) u_wr (
    .clk          (clk),
    .rst_n        (rst_n),
    .s_axi_awvalid(s_axi_awvalid),
    .s_axi_awready(s_axi_awready),
    .s_axi_awid   (s_axi_awid),
    .s_axi_awaddr (s_axi_awaddr),
    .s_axi_awlen  (s_axi_awlen),
    .s_axi_awsize (s_axi_awsize),
    .s_axi_awburst(s_axi_awburst),
    .s_axi_wvalid (s_axi_wvalid),
    .s_axi_wready (s_axi_wready),
    .s_axi_wdata  (s_axi_wdata),
    .s_axi_wstrb  (s_axi_wstrb),
    .s_axi_wlast  (s_axi_wlast),
    .s_axi_bvalid (s_axi_bvalid),
    .s_axi_bready (s_axi_bready),
    .s_axi_bid    (s_axi_bid),
    .s_axi_bresp  (s_axi_bresp),
    .sram         (u_wr_if.client)
  );

  sram_port_arb #(
    .AXI_ADDR_WIDTH(AXI_ADDR_WIDTH),
    .AXI_DATA_WIDTH(AXI_DATA_WIDTH),
    .AXI_ID_WIDTH  (AXI_ID_WIDTH)
  ) u_arb (
    .clk  (clk),
    .rst_n(rst_n),
    .rd   (u_rd_if.server),
    .wr   (u_wr_if.server)
  );

endmodule

`default_nettype wire

//--- verilog/axi_sram_wr.sv
`timescale 1ns/1ps
`default_nettype none

module axi_sram_wr #(
  parameter int AXI_ADDR_WIDTH = axi_sram_pkg::axi_addr_width,
  parameter int AXI_DATA_WIDTH = axi_sram_pkg::axi_data_width,
  parameter int AXI_ID_WIDTH   = axi_sram_pkg::axi_id_width
) (
  input  logic                        clk,
  input  logic                        rst_n,

  input  logic                        s_axi_awvalid,
  output logic                        s_axi_awready,
  input  logic [    AXI_ID_WIDTH-1:0] s_axi_awid,
  input  logic [  AXI_ADDR_WIDTH-1:0] s_axi_awaddr,
  input  logic [                 7:0] s_axi_awlen,
  input  logic [                 2:0] s_axi_awsize,
  input  logic [                 1:0] s_axi_awburst,

  input  logic                        s_axi_wvalid,
  output logic                        s_axi_wready,
  input  logic [  AXI_DATA_WIDTH-1:0] s_axi_wdata,
  input  logic [AXI_DATA_WIDTH/8-1:0] s_axi_wstrb,
  input  logic                        s_axi_wlast,

  output logic                        s_axi_bvalid,
  input  logic                        s_axi_bready,
  output logic [    AXI_ID_WIDTH-1:0] s_axi_bid,
  output logic [                 1:0] s_axi_bresp,

  sram_wr_if.client                   sram
);

  import axi_sram_pkg::*;

  localparam int ADDR_LSB = addr_lsb(AXI_DATA_WIDTH);
  localparam int SRAM_ADDR_WIDTH = AXI_ADDR_WIDTH - ADDR_LSB;

  logic                       w_active;
  logic                       b_valid;
  logic [SRAM_ADDR_WIDTH-1:0] word_addr;
  logic [   AXI_ID_WIDTH-1:0] burst_id;

  logic                       aw_fire;
  logic                       w_fire;
  logic                       b_fire;

  // No new AW until the previous burst has its B
  assign s_axi_awready = ~w_active & ~b_valid;
  assign aw_fire       = s_axi_awvalid & s_axi_awready;
  assign w_fire        = s_axi_wvalid & s_axi_wready;
  assign b_fire        = b_valid & s_axi_bready;

  always_ff @(posedge clk) begin
    if (~rst_n) begin
      w_active <= 1'b0;
      b_valid  <= 1'b0;
    end else begin
      if (aw_fire) begin
        w_active <= 1'b1;
      end else if (w_fire && s_axi_wlast) begin
        w_active <= 1'b0;
      end

      if (w_fire && s_axi_wlast) begin
        b_valid <= 1'b1;
      end else if (b_fire) begin
        b_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      word_addr <= s_axi_awaddr[AXI_ADDR_WIDTH-1:ADDR_LSB];
      burst_id  <= s_axi_awid;
    end else if (w_fire) begin
      word_addr <= word_addr + 1'b1;
    end
  end

  // W beats pass through as SRAM writes in the same cycle
  assign sram.cmd_valid = w_active & s_axi_wvalid;
  assign sram.cmd_addr  = word_addr;
  assign sram.cmd_data  = s_axi_wdata;
  assign sram.cmd_strb  = s_axi_wstrb;
  assign sram.cmd_last  = s_axi_wlast;
  assign s_axi_wready   = w_active & sram.cmd_ready;

  assign s_axi_bvalid = b_valid;
  assign s_axi_bid    = burst_id;
  assign s_axi_bresp  = resp_okay;

endmodule

`default_nettype wire

//--- verilog/sram_port_arb.sv
`timescale 1ns/1ps
`default_nettype none

module sram_port_arb #(
  parameter int AXI_ADDR_WIDTH = axi_sram_pkg::axi_addr_width,
  parameter int AXI_DATA_WIDTH = axi_sram_pkg::axi_data_width,
  parameter int AXI_ID_WIDTH   = axi_sram_pkg::axi_id_width
) (
  input  logic      clk,
  input  logic      rst_n,
  sram_rd_if.server rd,
  sram_wr_if.server wr
);

  import axi_sram_pkg::*;

  localparam int ADDR_LSB = addr_lsb(AXI_DATA_WIDTH);
  localparam int SRAM_ADDR_WIDTH = AXI_ADDR_WIDTH - ADDR_LSB;
  localparam int META_WIDTH = meta_width(AXI_ID_WIDTH);
  localparam int STRB_WIDTH = AXI_DATA_WIDTH / 8;

  logic [AXI_DATA_WIDTH-1:0] mem [2**SRAM_ADDR_WIDTH];

  logic                      turn_wr;
  logic                      resp_valid_q;
  logic [AXI_DATA_WIDTH-1:0] resp_data_q;
  logic [    META_WIDTH-1:0] resp_meta_q;

  logic                      rd_room;
  logic                      rd_req;
  logic                      wr_req;
  logic                      rd_grant;
  logic                      wr_grant;

  // A read needs a free response slot, or one draining now
  assign rd_room = ~resp_valid_q | rd.resp_ready;
  assign rd_req  = rd.cmd_valid & rd_room;
  assign wr_req  = wr.cmd_valid;

  // Ready does not look at the requester's own valid
  assign rd.cmd_ready = rd_room & (~wr_req | ~turn_wr);
  assign wr.cmd_ready = ~rd_req | turn_wr;

  assign rd_grant = rd.cmd_valid & rd.cmd_ready;
  assign wr_grant = wr.cmd_valid & wr.cmd_ready;

  // Whoever was just served yields to the other side
  always_ff @(posedge clk) begin
    if (~rst_n) begin
      turn_wr <= 1'b0;
    end else if (rd_grant) begin
      turn_wr <= 1'b1;
    end else if (wr_grant) begin
      turn_wr <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_grant) begin
      for (int i = 0; i < STRB_WIDTH; i++) begin
        if (wr.cmd_strb[i]) begin
          mem[wr.cmd_addr][i*8 +: 8] <= wr.cmd_data[i*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (~rst_n) begin
      resp_valid_q <= 1'b0;
    end else if (rd_grant) begin
      resp_valid_q <= 1'b1;
    end else if (rd.resp_ready) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_grant) begin
      resp_data_q <= mem[rd.cmd_addr];
      resp_meta_q <= rd.cmd_meta;
    end
  end

  assign rd.resp_valid = resp_valid_q;
  assign rd.resp_data  = resp_data_q;
  assign rd.resp_meta  = resp_meta_q;

endmodule

`default_nettype wire

//--- verilog/sram_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface sram_rd_if #(
  parameter int ADDR_WIDTH = 19,
  parameter int DATA_WIDTH = 16,
  parameter int META_WIDTH = 5
);

  logic                  cmd_valid;
  logic                  cmd_ready;
  logic [ADDR_WIDTH-1:0] cmd_addr;
  logic [META_WIDTH-1:0] cmd_meta;

  logic                  resp_valid;
  logic                  resp_ready;
  logic [DATA_WIDTH-1:0] resp_data;
  logic [META_WIDTH-1:0] resp_meta;

  modport client (
    output cmd_valid, cmd_addr, cmd_meta, resp_ready,
    input  cmd_ready, resp_valid, resp_data, resp_meta
  );

  modport server (
    input  cmd_valid, cmd_addr, cmd_meta, resp_ready,
    output cmd_ready, resp_valid, resp_data, resp_meta
  );

endinterface

`default_nettype wire

//--- verilog/sram_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

interface sram_wr_if #(
  parameter int ADDR_WIDTH = 19,
  parameter int DATA_WIDTH = 16,
  parameter int STRB_WIDTH = DATA_WIDTH / 8
);

  // A write is done once accepted, no response channel
  logic                  cmd_valid;
  logic                  cmd_ready;
  logic [ADDR_WIDTH-1:0] cmd_addr;
  logic [DATA_WIDTH-1:0] cmd_data;
  logic [STRB_WIDTH-1:0] cmd_strb;
  logic                  cmd_last;

  modport client (
    output cmd_valid, cmd_addr, cmd_data, cmd_strb, cmd_last,
    input  cmd_ready
  );

  modport server (
    input  cmd_valid, cmd_addr, cmd_data, cmd_strb, cmd_last,
    output cmd_ready
  );

endinterface

`default_nettype wire
